// ==== design/cdb_scheduler.sv ====
`timescale 1ns/10ps

module cdb_scheduler import tomasulo_pkg::*; #(
   parameter int MULT_LATENCY = mult_latency_c,
   parameter int DIV_LATENCY  = div_latency_c
) (
   input  logic         clk,
   input  logic         arst_n,
   input  unit_ready_t  ready,
   input  logic         div_busy,
   input  exec_result_t int_res,
   input  exec_result_t mult_res,
   input  exec_result_t div_res,
   input  exec_result_t ld_res,
   input  logic         branch,
   input  logic         branch_taken,
   output unit_ready_t  grant,
   output cdb_t         cdb,
   output logic         div_done
);

   // bit i marks a cdb slot taken i cycles from now
   logic [DIV_LATENCY-1:0]  slot_q;
   logic [DIV_LATENCY-1:0]  slot_d;
   logic [MULT_LATENCY-1:0] mult_pipe_q;
   logic [DIV_LATENCY-1:0]  div_pipe_q;
   logic                    mult_own;
   logic                    div_own;
   logic [data_width_c-1:0] hold_data_q;
   logic [tag_width_c-1:0]  hold_tag_q;

   // div first, then mult, then int ahead of loads
   always_comb begin
      grant          = '0;
      grant.div      = ready.div & ~div_busy;
      grant.mult     = ready.mult & ~slot_q[MULT_LATENCY];
      grant.int_unit = ready.int_unit & ~slot_q[0];
      grant.ldst     = ready.ldst & ~slot_q[0] & ~ready.int_unit;
   end

   always_comb begin
      slot_d                 = slot_q >> 1;
      slot_d[DIV_LATENCY-1]  = slot_d[DIV_LATENCY-1] | grant.div;
      slot_d[MULT_LATENCY-1] = slot_d[MULT_LATENCY-1] | grant.mult;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         slot_q      <= '0;
         mult_pipe_q <= '0;
         div_pipe_q  <= '0;
      end else begin
         slot_q      <= slot_d;
         mult_pipe_q <= {mult_pipe_q[MULT_LATENCY-2:0], grant.mult};
         div_pipe_q  <= {div_pipe_q[DIV_LATENCY-2:0], grant.div};
      end
   end

   // which pipelined unit owns this cycle's slot
   assign mult_own = mult_pipe_q[MULT_LATENCY-1];
   assign div_own  = div_pipe_q[DIV_LATENCY-1];
   assign div_done = div_own & div_res.valid;

   always_comb begin
      cdb.valid        = 1'b1;
      cdb.branch       = 1'b0;
      cdb.branch_taken = 1'b0;
      if (grant.int_unit && int_res.valid) begin
         cdb.data         = int_res.data;
         cdb.tag          = int_res.tag;
         cdb.branch       = branch;
         cdb.branch_taken = branch_taken;
      end else if (grant.ldst && ld_res.valid) begin
         cdb.data = ld_res.data;
         cdb.tag  = ld_res.tag;
      end else if (mult_own && mult_res.valid) begin
         cdb.data = mult_res.data;
         cdb.tag  = mult_res.tag;
      end else if (div_done) begin
         cdb.data = div_res.data;
         cdb.tag  = div_res.tag;
      end else begin
         // idle bus keeps the last word and tag
         cdb.valid = 1'b0;
         cdb.data  = hold_data_q;
         cdb.tag   = hold_tag_q;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hold_data_q <= '0;
         hold_tag_q  <= '0;
      end else begin
         hold_data_q <= cdb.data;
         hold_tag_q  <= cdb.tag;
      end
   end

endmodule

// ==== design/div_unit.sv ====
`timescale 1ns/10ps

module div_unit import tomasulo_pkg::*; #(
   parameter int DIV_LATENCY = div_latency_c
) (
   input  logic         clk,
   input  logic         arst_n,
   input  logic         start,
   input  issue_req_t   req,
   output exec_result_t result,
   output logic         busy
);

   // quotient bits retired per cycle
   localparam int step_bits_c = data_width_c / DIV_LATENCY;
   localparam int cnt_w_c     = $clog2(DIV_LATENCY);
   localparam logic [cnt_w_c-1:0] last_cnt_c = cnt_w_c'(DIV_LATENCY - 1);

   logic                      busy_q;
   logic [cnt_w_c-1:0]        cnt_q;
   logic [data_width_c-1:0]   rem_q;
   logic [data_width_c-1:0]   quo_q;
   logic [data_width_c-1:0]   dvs_q;
   logic [tag_width_c-1:0]    tag_q;
   logic [2*data_width_c-1:0] step_nxt;
   logic                      done;

   // restoring division over step_bits_c bits, returns {remainder, quotient}
   // a zero divisor always subtracts, so the quotient fills with ones
   function automatic logic [2*data_width_c-1:0] div_step(
      input logic [data_width_c-1:0] rem_in,
      input logic [data_width_c-1:0] quo_in,
      input logic [data_width_c-1:0] dvs
   );
      logic [data_width_c-1:0] rem;
      logic [data_width_c-1:0] quo;
      logic [data_width_c:0]   shifted;
      logic [data_width_c:0]   trial;
      rem = rem_in;
      quo = quo_in;
      for (int b = 0; b < step_bits_c; b++) begin
         shifted = {rem, quo[data_width_c-1]};
         trial   = shifted - {1'b0, dvs};
         quo     = quo << 1;
         if (!trial[data_width_c]) begin
            rem    = trial[data_width_c-1:0];
            quo[0] = 1'b1;
         end else begin
            rem = shifted[data_width_c-1:0];
         end
      end
      return {rem, quo};
   endfunction

   assign step_nxt = div_step(rem_q, quo_q, dvs_q);
   // last step is taken combinationally in the result cycle
   assign done     = busy_q && (cnt_q == last_cnt_c);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy_q <= 1'b0;
         cnt_q  <= '0;
      end else if (start) begin
         busy_q <= 1'b1;
         cnt_q  <= '0;
      end else if (done) begin
         busy_q <= 1'b0;
      end else if (busy_q) begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         rem_q <= '0;
         quo_q <= req.rs;
         dvs_q <= req.rt;
         tag_q <= req.tag;
      end else if (busy_q) begin
         {rem_q, quo_q} <= step_nxt;
      end
   end

   assign busy = busy_q;

   always_comb begin
      result.valid = done;
      result.data  = step_nxt[data_width_c-1:0];
      result.tag   = tag_q;
   end

endmodule

// ==== design/int_alu.sv ====
`timescale 1ns/10ps

module int_alu import tomasulo_pkg::*; (
   input  issue_req_t   req,
   input  logic         start,
   output exec_result_t result,
   output logic         carry,
   output logic         overflow,
   output logic         branch,
   output logic         branch_taken
);

   localparam int msb_c = data_width_c - 1;

   logic [data_width_c:0] sum;
   logic [data_width_c:0] diff;
   logic                  equal;

   assign sum   = {1'b0, req.rs} + {1'b0, req.rt};
   // subtract as rs + ~rt + 1, so carry high means no borrow
   assign diff  = {1'b0, req.rs} + {1'b0, ~req.rt} + 1'b1;
   assign equal = (req.rs == req.rt);

   always_comb begin
      result.valid = start;
      result.tag   = req.tag;
      result.data  = '0;
      carry        = 1'b0;
      overflow     = 1'b0;
      branch       = 1'b0;
      branch_taken = 1'b0;

      case (req.opcode)
         op_add: begin
            result.data = sum[msb_c:0];
            carry       = sum[data_width_c];
            overflow    = (req.rs[msb_c] == req.rt[msb_c]) &&
                          (sum[msb_c] != req.rs[msb_c]);
         end
         op_sub: begin
            result.data = diff[msb_c:0];
            carry       = diff[data_width_c];
            overflow    = (req.rs[msb_c] != req.rt[msb_c]) &&
                          (diff[msb_c] != req.rs[msb_c]);
         end
         op_and: begin
            result.data = req.rs & req.rt;
         end
         op_or: begin
            result.data = req.rs | req.rt;
         end
         op_xor: begin
            result.data = req.rs ^ req.rt;
         end
         op_slt: begin
            result.data = data_width_c'($signed(req.rs) < $signed(req.rt));
         end
         // branches resolve here, result word stays zero
         op_beq: begin
            branch       = 1'b1;
            branch_taken = equal;
         end
         op_bne: begin
            branch       = 1'b1;
            branch_taken = ~equal;
         end
         default: begin
            result.data = '0;
         end
      endcase
   end

endmodule

// ==== design/issue_unit.sv ====
`timescale 1ns/10ps

module issue_unit import tomasulo_pkg::*; #(
   parameter int MULT_LATENCY = mult_latency_c,
   parameter int DIV_LATENCY  = div_latency_c,
   parameter int MEM_DEPTH    = mem_depth_c
) (
   input  logic        clk,
   input  logic        arst_n,
   input  issue_req_t  req,
   input  unit_ready_t ready,
   output unit_ready_t grant,
   output cdb_t        cdb,
   output logic        div_done,
   output logic        store_done,
   output logic        carry,
   output logic        overflow
);

   exec_result_t int_res;
   exec_result_t mult_res;
   exec_result_t div_res;
   exec_result_t ld_res;
   logic         div_busy;
   logic         branch;
   logic         branch_taken;

   cdb_scheduler #(
      .MULT_LATENCY (MULT_LATENCY),
      .DIV_LATENCY  (DIV_LATENCY)
   ) u_sched (
      .clk          (clk),
      .arst_n       (arst_n),
      .ready        (ready),
      .div_busy     (div_busy),
      .int_res      (int_res),
      .mult_res     (mult_res),
      .div_res      (div_res),
      .ld_res       (ld_res),
      .branch       (branch),
      .branch_taken (branch_taken),
      .grant        (grant),
      .cdb          (cdb),
      .div_done     (div_done)
   );

   int_alu u_alu (
      .req          (req),
      .start        (grant.int_unit),
      .result       (int_res),
      .carry        (carry),
      .overflow     (overflow),
      .branch       (branch),
      .branch_taken (branch_taken)
   );

   mult_unit #(
      .MULT_LATENCY (MULT_LATENCY)
   ) u_mult (
      .clk    (clk),
      .arst_n (arst_n),
      .start  (grant.mult),
      .req    (req),
      .result (mult_res)
   );

   div_unit #(
      .DIV_LATENCY (DIV_LATENCY)
   ) u_div (
      .clk    (clk),
      .arst_n (arst_n),
      .start  (grant.div),
      .req    (req),
      .result (div_res),
      .busy   (div_busy)
   );

   load_store_unit #(
      .MEM_DEPTH (MEM_DEPTH)
   ) u_ldst (
      .clk        (clk),
      .arst_n     (arst_n),
      .start      (grant.ldst),
      .req        (req),
      .result     (ld_res),
      .store_done (store_done)
   );

endmodule

// ==== design/load_store_unit.sv ====
`timescale 1ns/10ps

module load_store_unit import tomasulo_pkg::*; #(
   parameter int MEM_DEPTH = mem_depth_c
) (
   input  logic         clk,
   input  logic         arst_n,
   input  logic         start,
   input  issue_req_t   req,
   output exec_result_t result,
   output logic         store_done
);

   localparam int addr_w_c = $clog2(MEM_DEPTH);

   logic [data_width_c-1:0] mem [MEM_DEPTH];
   logic [addr_w_c-1:0]     addr;
   logic                    do_store;

   // word address wraps over the memory depth
   assign addr     = addr_w_c'(req.rs % MEM_DEPTH);
   assign do_store = start & req.store;

   always_ff @(posedge clk) begin
      if (do_store) begin
         mem[addr] <= req.rt;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         store_done <= 1'b0;
      end else begin
         store_done <= do_store;
      end
   end

   // loads answer in the grant cycle, stores return nothing
   always_comb begin
      result.valid = start & ~req.store;
      result.data  = mem[addr];
      result.tag   = req.tag;
   end

endmodule

// ==== design/mult_unit.sv ====
`timescale 1ns/10ps

module mult_unit import tomasulo_pkg::*; #(
   parameter int MULT_LATENCY = mult_latency_c
) (
   input  logic         clk,
   input  logic         arst_n,
   input  logic         start,
   input  issue_req_t   req,
   output exec_result_t result
);

   localparam int half_c = data_width_c / 2;
   // product stages after the partial products and their sum
   localparam int tail_c = MULT_LATENCY - 2;

   logic [data_width_c-1:0]   pp_ll_q;
   logic [data_width_c-1:0]   pp_lh_q;
   logic [data_width_c-1:0]   pp_hl_q;
   logic [data_width_c-1:0]   pp_hh_q;
   logic [2*data_width_c-1:0] sum_q;
   logic [data_width_c-1:0]   prod_q [tail_c];
   logic [MULT_LATENCY-1:0]   valid_q;
   logic [tag_width_c-1:0]    tag_q [MULT_LATENCY];

   always_ff @(posedge clk) begin
      pp_ll_q <= req.rs[half_c-1:0]            * req.rt[half_c-1:0];
      pp_lh_q <= req.rs[half_c-1:0]            * req.rt[data_width_c-1:half_c];
      pp_hl_q <= req.rs[data_width_c-1:half_c] * req.rt[half_c-1:0];
      pp_hh_q <= req.rs[data_width_c-1:half_c] * req.rt[data_width_c-1:half_c];

      sum_q <= {pp_hh_q, {data_width_c{1'b0}}} +
               {{half_c{1'b0}}, pp_lh_q, {half_c{1'b0}}} +
               {{half_c{1'b0}}, pp_hl_q, {half_c{1'b0}}} +
               {{data_width_c{1'b0}}, pp_ll_q};

      // only the low word goes to the cdb
      prod_q[0] <= sum_q[data_width_c-1:0];
      for (int i = 1; i < tail_c; i++) begin
         prod_q[i] <= prod_q[i-1];
      end

      tag_q[0] <= req.tag;
      for (int i = 1; i < MULT_LATENCY; i++) begin
         tag_q[i] <= tag_q[i-1];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= '0;
      end else begin
         valid_q <= {valid_q[MULT_LATENCY-2:0], start};
      end
   end

   always_comb begin
      result.valid = valid_q[MULT_LATENCY-1];
      result.data  = prod_q[tail_c-1];
      result.tag   = tag_q[MULT_LATENCY-1];
   end

endmodule

// ==== design/tomasulo_pkg.sv ====
package tomasulo_pkg;

   localparam int data_width_c   = 32;
   localparam int tag_width_c    = 6;

   // default unit latencies, in cycles from grant to cdb
   localparam int mult_latency_c = 3;
   localparam int div_latency_c  = 8;

   // data memory words behind the load/store unit
   localparam int mem_depth_c    = 256;

   typedef enum logic [3:0] {
      op_add = 4'd0,
      op_sub = 4'd1,
      op_and = 4'd2,
      op_or  = 4'd3,
      op_xor = 4'd4,
      op_slt = 4'd5,
      op_beq = 4'd6,
      op_bne = 4'd7
   } alu_op_e;

   // one operation from the reservation stations
   typedef struct packed {
      alu_op_e                 opcode;
      logic [data_width_c-1:0] rs;
      logic [data_width_c-1:0] rt;
      logic [tag_width_c-1:0]  tag;
      logic                    store;
   } issue_req_t;

   typedef struct packed {
      logic                    valid;
      logic [data_width_c-1:0] data;
      logic [tag_width_c-1:0]  tag;
   } exec_result_t;

   typedef struct packed {
      logic                    valid;
      logic [data_width_c-1:0] data;
      logic [tag_width_c-1:0]  tag;
      logic                    branch;
      logic                    branch_taken;
   } cdb_t;

   // ready strobes and grants share this layout
   typedef struct packed {
      logic int_unit;
      logic mult;
      logic div;
      logic ldst;
   } unit_ready_t;

endpackage

// ==== issue_unit.f ====
design/tomasulo_pkg.sv
design/int_alu.sv
design/mult_unit.sv
design/div_unit.sv
design/load_store_unit.sv
design/cdb_scheduler.sv
design/issue_unit.sv
sim/issue_unit_tb.sv

// ==== sim/issue_unit_tb.sv ====
`timescale 1ns/10ps

module issue_unit_tb
   import tomasulo_pkg::*;
();

   typedef struct packed {
      logic [data_width_c-1:0] data;
      logic [tag_width_c-1:0]  tag;
      logic                    branch;
      logic                    taken;
   } expect_t;

   typedef struct packed {
      int      due;
      expect_t word;
      logic    is_div;
   } pending_t;

   // grant and ready masks, bit order int, mult, div, ldst
   localparam unit_ready_t int_sel  = 4'b1000;
   localparam unit_ready_t mult_sel = 4'b0100;
   localparam unit_ready_t div_sel  = 4'b0010;
   localparam unit_ready_t ldst_sel = 4'b0001;

   logic        clk;
   logic        arst_n;
   issue_req_t  req;
   unit_ready_t ready;
   unit_ready_t grant;
   cdb_t        cdb;
   logic        div_done;
   logic        store_done;
   logic        carry;
   logic        overflow;

   // reference model state
   pending_t                 pend_q [$];
   logic [data_width_c-1:0]  ref_mem [mem_depth_c];
   logic [div_latency_c-1:0] slot = '0;
   int                       div_left = 0;
   logic                     st_pend = 1'b0;
   int                       cyc = 0;

   unit_ready_t exp_grant = '0;
   logic        exp_valid = 1'b0;
   expect_t     exp_word = '0;
   logic        hold_known = 1'b0;
   logic        exp_div_done = 1'b0;
   logic        exp_store_done = 1'b0;
   logic        exp_flag_chk = 1'b0;
   logic [1:0]  exp_flags = '0;
   expect_t     cdb_word;

   int                      errors = 0;
   int                      n_checked = 0;
   logic [31:0]             seed = 32'd42;
   string                   test_name = "reset";
   logic [data_width_c-1:0] addrs [4];

   issue_unit UUT (
      .clk        (clk),
      .arst_n     (arst_n),
      .req        (req),
      .ready      (ready),
      .grant      (grant),
      .cdb        (cdb),
      .div_done   (div_done),
      .store_done (store_done),
      .carry      (carry),
      .overflow   (overflow)
   );

   assign cdb_word = {cdb.data, cdb.tag, cdb.branch, cdb.branch_taken};

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      seed = seed * 32'd1103515245 + 32'd12345;
      return seed;
   endfunction

   function automatic issue_req_t make_req(input alu_op_e op, input logic [31:0] rs,
                                           input logic [31:0] rt, input logic store);
      issue_req_t r;
      r.opcode = op;
      r.rs     = rs;
      r.rt     = rt;
      r.tag    = tag_width_c'(lcg_next() >> 26);
      r.store  = store;
      return r;
   endfunction

   // expected integer result, flags as {carry, overflow}
   function automatic expect_t alu_expect(input issue_req_t r, output logic [1:0] flags);
      expect_t e;
      longint  a;
      longint  b;
      longint  wide;
      a = longint'($signed(r.rs));
      b = longint'($signed(r.rt));
      e = '0;
      e.tag = r.tag;
      flags = 2'b00;
      case (r.opcode)
         op_add: begin
            wide = a + b;
            e.data = r.rs + r.rt;
            flags = {(64'(r.rs) + 64'(r.rt)) > 64'hffff_ffff,
                     wide != longint'($signed(e.data))};
         end
         op_sub: begin
            wide = a - b;
            e.data = r.rs - r.rt;
            flags = {r.rs >= r.rt, wide != longint'($signed(e.data))};
         end
         op_and: e.data = r.rs & r.rt;
         op_or:  e.data = r.rs | r.rt;
         op_xor: e.data = r.rs ^ r.rt;
         op_slt: e.data = data_width_c'(a < b);
         op_beq: begin
            e.branch = 1'b1;
            e.taken  = (r.rs == r.rt);
         end
         op_bne: begin
            e.branch = 1'b1;
            e.taken  = (r.rs != r.rt);
         end
         default: e.data = '0;
      endcase
      return e;
   endfunction

   task automatic report_mismatch(input string what, input logic [39:0] expected,
                                  input logic [39:0] actual);
      errors++;
      $display("ERROR %s: %s expected %h actual %h", test_name, what, expected, actual);
   endtask

   // holds the strobes until each unit takes the request
   task automatic issue(input issue_req_t r, input unit_ready_t mask);
      unit_ready_t left;
      int          waited;
      left = mask;
      waited = 0;
      req <= r;
      ready <= left;
      while (left != '0 && waited < 20) begin
         @(negedge clk);
         left = unit_ready_t'(left & ~grant);
         waited++;
         @(posedge clk);
         ready <= left;
      end
      if (left != '0) begin
         errors++;
         $display("%s: request with tag %0d was not granted in 20 cycles", test_name, r.tag);
      end
   endtask

   task automatic idle(input int n);
      repeat (n) @(posedge clk);
   endtask

   always @(negedge clk) begin : ref_model
      unit_ready_t             g;
      expect_t                 w;
      logic [1:0]              fl;
      logic [data_width_c-1:0] quo;
      g = '0;
      exp_valid = 1'b0;
      exp_div_done = 1'b0;
      exp_flag_chk = 1'b0;
      if (!arst_n) begin
         pend_q.delete();
         slot = '0;
         div_left = 0;
         st_pend = 1'b0;
         exp_store_done = 1'b0;
         hold_known = 1'b0;
      end else begin
         g.div      = ready.div && (div_left == 0);
         g.mult     = ready.mult && !slot[mult_latency_c];
         g.int_unit = ready.int_unit && !slot[0];
         g.ldst     = ready.ldst && !slot[0] && !ready.int_unit;
         if (g.int_unit) begin
            w = alu_expect(req, fl);
            pend_q.push_back('{cyc, w, 1'b0});
            exp_flag_chk = (req.opcode == op_add) || (req.opcode == op_sub);
            exp_flags = fl;
         end
         if (g.ldst && !req.store) begin
            w = '{ref_mem[req.rs % mem_depth_c], req.tag, 1'b0, 1'b0};
            pend_q.push_back('{cyc, w, 1'b0});
         end
         if (g.ldst && req.store) begin
            ref_mem[req.rs % mem_depth_c] = req.rt;
         end
         if (g.mult) begin
            w = '{data_width_c'(64'(req.rs) * 64'(req.rt)), req.tag, 1'b0, 1'b0};
            pend_q.push_back('{cyc + mult_latency_c, w, 1'b0});
         end
         if (g.div) begin
            quo = (req.rt == '0) ? {data_width_c{1'b1}} : req.rs / req.rt;
            w = '{quo, req.tag, 1'b0, 1'b0};
            pend_q.push_back('{cyc + div_latency_c, w, 1'b1});
         end
         exp_store_done = st_pend;
         st_pend = g.ldst && req.store;
         if (div_left > 0) begin
            div_left--;
         end
         if (g.div) begin
            div_left = div_latency_c;
         end
         slot = slot >> 1;
         slot[div_latency_c-1]  = slot[div_latency_c-1] | g.div;
         slot[mult_latency_c-1] = slot[mult_latency_c-1] | g.mult;
      end
      exp_grant = g;
      for (int i = pend_q.size() - 1; i >= 0; i--) begin
         if (pend_q[i].due == cyc) begin
            exp_valid = 1'b1;
            exp_word = pend_q[i].word;
            exp_div_done = pend_q[i].is_div;
            pend_q.delete(i);
         end
      end
      if (exp_valid) begin
         n_checked++;
         hold_known = 1'b1;
      end
      cyc++;
   end

   a_grant: assert property (@(posedge clk) grant == exp_grant)
      else report_mismatch("grant", $sampled(exp_grant), $sampled(grant));
   a_valid: assert property (@(posedge clk) cdb.valid == exp_valid)
      else report_mismatch("cdb valid", $sampled(exp_valid), $sampled(cdb.valid));
   a_word: assert property (@(posedge clk) exp_valid |-> cdb_word == exp_word)
      else report_mismatch("cdb word", $sampled(exp_word), $sampled(cdb_word));
   // idle bus shows the last result word and tag
   a_hold: assert property (@(posedge clk)
         hold_known && !exp_valid |-> {cdb.data, cdb.tag} == {exp_word.data, exp_word.tag})
      else report_mismatch("cdb hold", $sampled({exp_word.data, exp_word.tag}),
                           $sampled({cdb.data, cdb.tag}));
   a_div_done: assert property (@(posedge clk) div_done == exp_div_done)
      else report_mismatch("div_done", $sampled(exp_div_done), $sampled(div_done));
   a_store_done: assert property (@(posedge clk) store_done == exp_store_done)
      else report_mismatch("store_done", $sampled(exp_store_done), $sampled(store_done));
   a_flags: assert property (@(posedge clk) exp_flag_chk |-> {carry, overflow} == exp_flags)
      else report_mismatch("carry/overflow", $sampled(exp_flags), $sampled({carry, overflow}));

   initial begin
      issue_req_t r;
      req = '0;
      ready = '0;
      arst_n = 1'b0;
      repeat (8) @(posedge clk);
      arst_n <= 1'b1;
      idle(2);

      test_name = "int_ops";
      for (int op = 0; op < 8; op++) begin
         for (int k = 0; k < 2; k++) begin
            r = make_req(alu_op_e'(op), lcg_next(), lcg_next(), 1'b0);
            // second pass makes the branch operands equal
            if (k == 1) begin
               r.rt = r.rs;
            end
            issue(r, int_sel);
         end
      end
      issue(make_req(op_add, 32'h7fff_ffff, 32'd1, 1'b0), int_sel);
      issue(make_req(op_sub, 32'h8000_0000, 32'd1, 1'b0), int_sel);

      test_name = "mult";
      repeat (4) issue(make_req(op_add, lcg_next(), lcg_next(), 1'b0), mult_sel);
      idle(5);

      test_name = "div";
      issue(make_req(op_add, lcg_next(), lcg_next() >> 20, 1'b0), div_sel);
      issue(make_req(op_add, lcg_next(), lcg_next() >> 26, 1'b0), div_sel);
      issue(make_req(op_add, lcg_next(), 32'd0, 1'b0), div_sel);
      idle(10);

      test_name = "store_load";
      for (int i = 0; i < 4; i++) begin
         addrs[i] = lcg_next();
         issue(make_req(op_add, addrs[i], lcg_next(), 1'b1), ldst_sel);
      end
      for (int i = 0; i < 4; i++) begin
         issue(make_req(op_add, addrs[i], 32'd0, 1'b0), ldst_sel);
      end

      test_name = "contention";
      issue(make_req(op_add, addrs[0], lcg_next(), 1'b0), unit_ready_t'(int_sel | ldst_sel));
      // mult and int land on the divide slot and wait
      issue(make_req(op_add, lcg_next(), lcg_next() >> 16, 1'b0), div_sel);
      idle(4);
      issue(make_req(op_add, lcg_next(), lcg_next(), 1'b0), mult_sel);
      idle(1);
      issue(make_req(op_add, lcg_next(), lcg_next(), 1'b0), int_sel);
      idle(10);

      test_name = "reset";
      issue(make_req(op_add, lcg_next(), lcg_next() >> 24, 1'b0), div_sel);
      idle(3);
      arst_n <= 1'b0;
      idle(8);
      arst_n <= 1'b1;
      idle(12);

      idle(2);
      $display("%0d errors, %0d cdb results checked", errors, n_checked);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule
